// ==== rtl/wasm_pkg.sv ====
package wasm_pkg;

  // Code memory and fetch window
  localparam int CODE_ADDR_W = 6;
  localparam int LEB_BYTES   = 10;
  localparam int FETCH_BYTES = LEB_BYTES + 1;

  // Operand stack
  localparam int STACK_DEPTH = 16;
  localparam int DEPTH_W     = 5;

  typedef enum logic [1:0] {
    VT_I32 = 2'd0,
    VT_I64 = 2'd1
  } val_type_e;

  typedef struct packed {
    val_type_e   vtype;
    logic [63:0] value;
  } stack_entry_t;

  // WebAssembly binary encodings
  typedef enum logic [7:0] {
    OP_UNREACHABLE = 8'h00,
    OP_NOP         = 8'h01,
    OP_END         = 8'h0B,
    OP_DROP        = 8'h1A,
    OP_SELECT      = 8'h1B,
    OP_I32_CONST   = 8'h41,
    OP_I64_CONST   = 8'h42,
    OP_I32_EQZ     = 8'h45,
    OP_I32_EQ      = 8'h46,
    OP_I32_NE      = 8'h47,
    OP_I64_EQZ     = 8'h50,
    OP_I64_EQ      = 8'h51,
    OP_I64_NE      = 8'h52,
    OP_I32_ADD     = 8'h6A,
    OP_I32_SUB     = 8'h6B,
    OP_I64_ADD     = 8'h7C,
    OP_I64_SUB     = 8'h7D
  } opcode_e;

  typedef enum logic [2:0] {
    TRAP_NONE           = 3'd0,
    TRAP_ENDED          = 3'd1,
    TRAP_UNREACHABLE    = 3'd2,
    TRAP_TYPE_MISMATCH  = 3'd3,
    TRAP_STACK_EMPTY    = 3'd4,
    TRAP_STACK_FULL     = 3'd5,
    TRAP_UNKNOWN_OPCODE = 3'd6
  } trap_e;

  typedef enum logic [2:0] {
    ST_NONE         = 3'd0,
    ST_PUSH         = 3'd1,
    ST_REPLACE      = 3'd2,
    ST_POP          = 3'd3,
    ST_POP_REPLACE  = 3'd4,
    ST_POP2_REPLACE = 3'd5
  } stack_op_e;

  typedef struct packed {
    logic                   en;
    logic [CODE_ADDR_W-1:0] addr;
    logic [7:0]             data;
  } code_load_t;

  typedef struct packed {
    stack_op_e    op;
    stack_entry_t data;
  } stack_cmd_t;

endpackage

// ==== rtl/code_mem.sv ====
module code_mem (
  input  logic                                    clk,
  input  wasm_pkg::code_load_t                    load,
  input  logic [wasm_pkg::CODE_ADDR_W-1:0]        fetch_addr,
  output logic [wasm_pkg::FETCH_BYTES-1:0][7:0]   window
);

  logic [7:0] mem [2**wasm_pkg::CODE_ADDR_W];

  // Byte write port, used while the core sits in reset
  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load.addr] <= load.data;
    end
  end

  // Opcode plus the longest immediate in one read
  // Addresses past the top wrap back to 0
  always_ff @(posedge clk) begin
    for (int i = 0; i < wasm_pkg::FETCH_BYTES; i++) begin
      window[i] <= mem[fetch_addr + wasm_pkg::CODE_ADDR_W'(i)];
    end
  end

endmodule

// ==== rtl/leb128_decoder.sv ====
module leb128_decoder (
  input  logic [wasm_pkg::LEB_BYTES-1:0][7:0] bytes,
  output logic [63:0]                         imm_value,
  output logic [3:0]                          imm_len
);

  // Seven payload bits per byte, low group first
  logic [7*wasm_pkg::LEB_BYTES-1:0] groups;
  logic [3:0]                       last;
  logic                             found;
  logic [6:0]                       used_bits;
  logic [63:0]                      sign_fill;

  // First byte with bit 7 clear ends the number
  always_comb begin
    found = 1'b0;
    last  = 4'(wasm_pkg::LEB_BYTES - 1);
    for (int i = 0; i < wasm_pkg::LEB_BYTES; i++) begin
      if (!found && !bytes[i][7]) begin
        found = 1'b1;
        last  = 4'(i);
      end
    end
  end

  // Bytes after the terminator do not belong to the immediate
  always_comb begin
    groups = '0;
    for (int i = 0; i < wasm_pkg::LEB_BYTES; i++) begin
      if (4'(i) <= last) begin
        groups[7*i +: 7] = bytes[i][6:0];
      end
    end
  end

  assign imm_len   = last + 4'd1;
  assign used_bits = 7'd7 * ({3'b000, last} + 7'd1);

  // Sign from bit 6 of the last byte, nothing left to fill past 63
  assign sign_fill = bytes[last][6] ? ((~64'd0) << used_bits) : 64'd0;
  assign imm_value = groups[63:0] | sign_fill;

endmodule

// ==== rtl/int_alu.sv ====
module int_alu (
  input  wasm_pkg::opcode_e      opcode,
  input  wasm_pkg::stack_entry_t tos,
  input  wasm_pkg::stack_entry_t nos,
  input  wasm_pkg::stack_entry_t third,
  output wasm_pkg::stack_entry_t alu_data,
  output logic                   type_ok
);

  logic        tos_i32;
  logic        tos_i64;
  logic        both_i32;
  logic        both_i64;
  logic        eq32;
  logic        eq64;
  logic [31:0] sum32;
  logic [31:0] diff32;

  assign tos_i32  = tos.vtype == wasm_pkg::VT_I32;
  assign tos_i64  = tos.vtype == wasm_pkg::VT_I64;
  assign both_i32 = tos_i32 && nos.vtype == wasm_pkg::VT_I32;
  assign both_i64 = tos_i64 && nos.vtype == wasm_pkg::VT_I64;

  assign eq32   = nos.value[31:0] == tos.value[31:0];
  assign eq64   = nos.value == tos.value;
  // Second operand pushed is subtracted from the first
  assign sum32  = nos.value[31:0] + tos.value[31:0];
  assign diff32 = nos.value[31:0] - tos.value[31:0];

  always_comb begin
    alu_data.vtype = wasm_pkg::VT_I32;
    alu_data.value = 64'd0;
    type_ok        = 1'b1;
    case (opcode)
      wasm_pkg::OP_I32_EQZ: begin
        type_ok        = tos_i32;
        alu_data.value = {63'd0, tos.value[31:0] == 32'd0};
      end
      wasm_pkg::OP_I64_EQZ: begin
        type_ok        = tos_i64;
        alu_data.value = {63'd0, tos.value == 64'd0};
      end
      wasm_pkg::OP_I32_EQ: begin
        type_ok        = both_i32;
        alu_data.value = {63'd0, eq32};
      end
      wasm_pkg::OP_I32_NE: begin
        type_ok        = both_i32;
        alu_data.value = {63'd0, !eq32};
      end
      wasm_pkg::OP_I64_EQ: begin
        type_ok        = both_i64;
        alu_data.value = {63'd0, eq64};
      end
      wasm_pkg::OP_I64_NE: begin
        type_ok        = both_i64;
        alu_data.value = {63'd0, !eq64};
      end
      wasm_pkg::OP_I32_ADD: begin
        type_ok        = both_i32;
        alu_data.value = {32'd0, sum32};
      end
      wasm_pkg::OP_I32_SUB: begin
        type_ok        = both_i32;
        alu_data.value = {32'd0, diff32};
      end
      wasm_pkg::OP_I64_ADD: begin
        type_ok        = both_i64;
        alu_data.vtype = wasm_pkg::VT_I64;
        alu_data.value = nos.value + tos.value;
      end
      wasm_pkg::OP_I64_SUB: begin
        type_ok        = both_i64;
        alu_data.vtype = wasm_pkg::VT_I64;
        alu_data.value = nos.value - tos.value;
      end
      wasm_pkg::OP_SELECT: begin
        // Condition on top, first pushed value is the deepest
        type_ok  = tos_i32 && nos.vtype == third.vtype;
        alu_data = (tos.value[31:0] != 32'd0) ? third : nos;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== rtl/exec_ctrl.sv ====
module exec_ctrl (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [wasm_pkg::FETCH_BYTES-1:0][7:0] window,
  input  logic [63:0]                           imm_value,
  input  logic [3:0]                            imm_len,
  input  wasm_pkg::stack_entry_t                alu_data,
  input  logic                                  type_ok,
  input  logic [wasm_pkg::DEPTH_W-1:0]          depth,
  output logic [wasm_pkg::CODE_ADDR_W-1:0]      fetch_addr,
  output wasm_pkg::opcode_e                     opcode,
  output wasm_pkg::stack_cmd_t                  stack_cmd,
  output wasm_pkg::trap_e                       trap
);

  typedef enum logic {
    STEP_FETCH,
    STEP_EXEC
  } step_e;

  step_e                            step;
  logic [wasm_pkg::CODE_ADDR_W-1:0] pc;

  // Decode of the current window
  wasm_pkg::stack_cmd_t cmd;
  wasm_pkg::trap_e      exec_trap;
  logic [1:0]           need;
  logic                 has_imm;

  assign opcode     = wasm_pkg::opcode_e'(window[0]);
  assign fetch_addr = pc;

  always_comb begin
    cmd.op    = wasm_pkg::ST_NONE;
    cmd.data  = alu_data;
    need      = 2'd0;
    has_imm   = 1'b0;
    exec_trap = wasm_pkg::TRAP_NONE;
    case (opcode)
      wasm_pkg::OP_NOP: begin
      end
      wasm_pkg::OP_UNREACHABLE: exec_trap = wasm_pkg::TRAP_UNREACHABLE;
      // Function level end halts the core
      wasm_pkg::OP_END: exec_trap = wasm_pkg::TRAP_ENDED;
      wasm_pkg::OP_I32_CONST: begin
        cmd.op         = wasm_pkg::ST_PUSH;
        cmd.data.vtype = wasm_pkg::VT_I32;
        cmd.data.value = {32'd0, imm_value[31:0]};
        has_imm        = 1'b1;
      end
      wasm_pkg::OP_I64_CONST: begin
        cmd.op         = wasm_pkg::ST_PUSH;
        cmd.data.vtype = wasm_pkg::VT_I64;
        cmd.data.value = imm_value;
        has_imm        = 1'b1;
      end
      wasm_pkg::OP_DROP: begin
        cmd.op = wasm_pkg::ST_POP;
        need   = 2'd1;
      end
      wasm_pkg::OP_I32_EQZ,
      wasm_pkg::OP_I64_EQZ: begin
        cmd.op = wasm_pkg::ST_REPLACE;
        need   = 2'd1;
      end
      wasm_pkg::OP_I32_EQ,
      wasm_pkg::OP_I32_NE,
      wasm_pkg::OP_I64_EQ,
      wasm_pkg::OP_I64_NE,
      wasm_pkg::OP_I32_ADD,
      wasm_pkg::OP_I32_SUB,
      wasm_pkg::OP_I64_ADD,
      wasm_pkg::OP_I64_SUB: begin
        cmd.op = wasm_pkg::ST_POP_REPLACE;
        need   = 2'd2;
      end
      wasm_pkg::OP_SELECT: begin
        cmd.op = wasm_pkg::ST_POP2_REPLACE;
        need   = 2'd3;
      end
      default: exec_trap = wasm_pkg::TRAP_UNKNOWN_OPCODE;
    endcase

    // Depth first, types are meaningless on missing operands
    if (exec_trap == wasm_pkg::TRAP_NONE) begin
      if (depth < wasm_pkg::DEPTH_W'(need)) begin
        exec_trap = wasm_pkg::TRAP_STACK_EMPTY;
      end else if (cmd.op == wasm_pkg::ST_PUSH &&
                   depth == wasm_pkg::DEPTH_W'(wasm_pkg::STACK_DEPTH)) begin
        exec_trap = wasm_pkg::TRAP_STACK_FULL;
      end else if (!type_ok) begin
        exec_trap = wasm_pkg::TRAP_TYPE_MISMATCH;
      end
    end
  end

  // Stack moves only in an EXEC cycle that does not trap
  always_comb begin
    stack_cmd = cmd;
    if (step != STEP_EXEC || trap != wasm_pkg::TRAP_NONE ||
        exec_trap != wasm_pkg::TRAP_NONE) begin
      stack_cmd.op = wasm_pkg::ST_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      step <= STEP_FETCH;
      pc   <= '0;
      trap <= wasm_pkg::TRAP_NONE;
    end else if (trap == wasm_pkg::TRAP_NONE) begin
      case (step)
        STEP_FETCH: step <= STEP_EXEC;
        STEP_EXEC: begin
          step <= STEP_FETCH;
          trap <= exec_trap;
          // Skip the immediate bytes of a constant
          if (exec_trap == wasm_pkg::TRAP_NONE) begin
            pc <= pc + wasm_pkg::CODE_ADDR_W'(has_imm ? imm_len : 4'd0) + 1'b1;
          end
        end
        default: step <= STEP_FETCH;
      endcase
    end
  end

endmodule

// ==== rtl/operand_stack.sv ====
module operand_stack (
  input  logic                         clk,
  input  logic                         reset,
  input  wasm_pkg::stack_cmd_t         cmd,
  output wasm_pkg::stack_entry_t       tos,
  output wasm_pkg::stack_entry_t       nos,
  output wasm_pkg::stack_entry_t       third,
  output logic [wasm_pkg::DEPTH_W-1:0] depth,
  output logic                         empty
);

  wasm_pkg::stack_entry_t entries [wasm_pkg::STACK_DEPTH];

  // Slot indices, one bit narrower than the depth count
  logic [wasm_pkg::DEPTH_W-2:0] idx_free;
  logic [wasm_pkg::DEPTH_W-2:0] idx_top;
  logic [wasm_pkg::DEPTH_W-2:0] idx_nos;
  logic [wasm_pkg::DEPTH_W-2:0] idx_third;

  assign idx_free  = depth[wasm_pkg::DEPTH_W-2:0];
  assign idx_top   = idx_free - 1'b1;
  assign idx_nos   = idx_free - 2'd2;
  assign idx_third = idx_free - 2'd3;

  // Below three entries the deeper outputs are don't care
  assign tos   = entries[idx_top];
  assign nos   = entries[idx_nos];
  assign third = entries[idx_third];
  assign empty = depth == '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      depth <= '0;
    end else begin
      case (cmd.op)
        wasm_pkg::ST_PUSH:         depth <= depth + 1'b1;
        wasm_pkg::ST_POP,
        wasm_pkg::ST_POP_REPLACE:  depth <= depth - 1'b1;
        wasm_pkg::ST_POP2_REPLACE: depth <= depth - 2'd2;
        default: begin
        end
      endcase
    end
  end

  // Result lands where the deepest consumed operand was
  always_ff @(posedge clk) begin
    case (cmd.op)
      wasm_pkg::ST_PUSH:         entries[idx_free]  <= cmd.data;
      wasm_pkg::ST_REPLACE:      entries[idx_top]   <= cmd.data;
      wasm_pkg::ST_POP_REPLACE:  entries[idx_nos]   <= cmd.data;
      wasm_pkg::ST_POP2_REPLACE: entries[idx_third] <= cmd.data;
      default: begin
      end
    endcase
  end

endmodule

// ==== rtl/wasm_core.sv ====
module wasm_core (
  input  logic                   clk,
  input  logic                   reset,
  input  wasm_pkg::code_load_t   load,
  output wasm_pkg::stack_entry_t result,
  output logic                   result_empty,
  output wasm_pkg::trap_e        trap
);

  logic [wasm_pkg::FETCH_BYTES-1:0][7:0] window;
  logic [wasm_pkg::CODE_ADDR_W-1:0]      fetch_addr;
  logic [63:0]                           imm_value;
  logic [3:0]                            imm_len;
  wasm_pkg::opcode_e                     opcode;
  wasm_pkg::stack_entry_t                alu_data;
  logic                                  type_ok;
  wasm_pkg::stack_cmd_t                  stack_cmd;
  wasm_pkg::stack_entry_t                tos;
  wasm_pkg::stack_entry_t                nos;
  wasm_pkg::stack_entry_t                third;
  logic [wasm_pkg::DEPTH_W-1:0]          depth;

  // Top of stack is the visible result
  assign result = tos;

  code_mem i_code_mem (
    .clk       (clk),
    .load      (load),
    .fetch_addr(fetch_addr),
    .window    (window)
  );

  // Immediate starts right after the opcode byte
  leb128_decoder i_leb128_decoder (
    .bytes    (window[wasm_pkg::FETCH_BYTES-1:1]),
    .imm_value(imm_value),
    .imm_len  (imm_len)
  );

  exec_ctrl i_exec_ctrl (
    .clk       (clk),
    .reset     (reset),
    .window    (window),
    .imm_value (imm_value),
    .imm_len   (imm_len),
    .alu_data  (alu_data),
    .type_ok   (type_ok),
    .depth     (depth),
    .fetch_addr(fetch_addr),
    .opcode    (opcode),
    .stack_cmd (stack_cmd),
    .trap      (trap)
  );

  int_alu i_int_alu (
    .opcode  (opcode),
    .tos     (tos),
    .nos     (nos),
    .third   (third),
    .alu_data(alu_data),
    .type_ok (type_ok)
  );

  operand_stack i_operand_stack (
    .clk  (clk),
    .reset(reset),
    .cmd  (stack_cmd),
    .tos  (tos),
    .nos  (nos),
    .third(third),
    .depth(depth),
    .empty(result_empty)
  );

endmodule

// ==== tests/wasm_core_chk.sv ====
module wasm_core_chk (
  input logic                   clk,
  input logic                   reset,
  input wasm_pkg::trap_e        trap,
  input wasm_pkg::stack_entry_t result,
  input logic                   result_empty
);

  int assert_failures = 0;

  // A halted core keeps its trap code until reset
  trap_sticky: assert property (@(posedge clk) disable iff (reset)
      trap != wasm_pkg::TRAP_NONE |=> $stable(trap))
    else begin
      assert_failures++;
      $error("trap code changed while the core was halted");
    end

  // No stack traffic once halted, an empty stack has no defined top
  result_frozen: assert property (@(posedge clk) disable iff (reset)
      trap != wasm_pkg::TRAP_NONE |=>
      $stable(result_empty) && (result_empty || $stable(result)))
    else begin
      assert_failures++;
      $error("result moved while the core was halted");
    end

  reset_clears_trap: assert property (@(posedge clk)
      reset |=> trap == wasm_pkg::TRAP_NONE)
    else begin
      assert_failures++;
      $error("trap was not cleared by reset");
    end

endmodule

bind wasm_core wasm_core_chk i_chk (
  .clk         (clk),
  .reset       (reset),
  .trap        (trap),
  .result      (result),
  .result_empty(result_empty)
);

// ==== tests/wasm_core_tb.sv ====
module wasm_core_tb;

  // First program byte sits in the highest used byte of prog
  typedef struct packed {
    logic [319:0]        prog;
    logic [5:0]          len;
    wasm_pkg::trap_e     trap;
    logic                empty;
    wasm_pkg::val_type_e vtype;
    logic [63:0]         value;
  } test_row_t;

  logic                   clk;
  logic                   reset;
  wasm_pkg::code_load_t   load;
  wasm_pkg::stack_entry_t result;
  logic                   result_empty;
  wasm_pkg::trap_e        trap;

  test_row_t rows[$];
  string     names[$];
  int        error_count;
  int        pass_count;
  int        fail_count;
  int        cycle_limit;
  int        run_cycles;

  wasm_core i_dut (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .result      (result),
    .result_empty(result_empty),
    .trap        (trap)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Count only cycles with the core out of reset
  always @(posedge clk) begin
    if (!reset) begin
      run_cycles++;
      if (run_cycles > cycle_limit) begin
        $display("timeout: core did not halt within %0d running cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
      end
    end
  end

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h, expected %h", what, actual, expected);
      error_count++;
    end
  endtask

  task automatic add_test(input string name, input int len, input logic [319:0] prog,
                          input wasm_pkg::trap_e trap_exp, input logic empty_exp,
                          input wasm_pkg::val_type_e vtype_exp, input logic [63:0] value_exp);
    test_row_t row;
    row.prog  = prog;
    row.len   = 6'(len);
    row.trap  = trap_exp;
    row.empty = empty_exp;
    row.vtype = vtype_exp;
    row.value = value_exp;
    rows.push_back(row);
    names.push_back(name);
    // Two cycles per byte and 20 cycles of slack
    cycle_limit += 2 * len + 20;
  endtask

  task automatic build_table();
    // Signed LEB128 constants of various lengths
    add_test("i32_const_multi", 5, 320'h41_E5_8E_26_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h0009_8765);
    add_test("i32_const_neg", 5, 320'h41_C0_BB_78_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'hFFFE_1DC0);
    add_test("i32_const_min", 7, 320'h41_80_80_80_80_78_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h8000_0000);
    add_test("i64_const_neg", 5, 320'h42_C0_BB_78_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I64, 64'hFFFF_FFFF_FFFE_1DC0);
    add_test("i64_const_ten_bytes", 12, 320'h42_80_80_80_80_80_80_80_80_80_7F_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I64, 64'h8000_0000_0000_0000);
    // Arithmetic and compares
    add_test("i32_add_wrap", 6, 320'h41_7F_41_02_6A_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h1);
    add_test("i32_sub_order", 6, 320'h41_05_41_07_6B_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'hFFFF_FFFE);
    add_test("i64_add_wrap", 15, 320'h42_80_80_80_80_80_80_80_80_80_7F_42_7F_7C_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I64, 64'h7FFF_FFFF_FFFF_FFFF);
    add_test("i64_sub_order", 6, 320'h42_03_42_0A_7D_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I64, 64'hFFFF_FFFF_FFFF_FFF9);
    add_test("i32_eq_true", 6, 320'h41_2A_41_2A_46_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h1);
    add_test("i32_eq_false", 6, 320'h41_2A_41_2B_46_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h0);
    add_test("i32_ne_true", 6, 320'h41_2A_41_2B_47_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h1);
    add_test("i32_ne_false", 6, 320'h41_2A_41_2A_47_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h0);
    add_test("i64_eq_upper", 11, 320'h42_01_42_81_80_80_80_80_01_51_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h0);
    add_test("i64_eq_true", 6, 320'h42_05_42_05_51_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h1);
    add_test("i64_ne_equal", 6, 320'h42_05_42_05_52_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h0);
    add_test("i64_ne_upper", 11, 320'h42_01_42_81_80_80_80_80_01_52_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h1);
    add_test("i32_eqz_zero", 4, 320'h41_00_45_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h1);
    add_test("i32_eqz_nonzero", 4, 320'h41_03_45_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h0);
    add_test("i64_eqz_zero", 4, 320'h42_00_50_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h1);
    add_test("i64_eqz_nonzero", 4, 320'h42_03_50_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h0);
    // Stack shuffling
    add_test("drop_top", 6, 320'h41_01_41_02_1A_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h1);
    add_test("select_true", 8, 320'h41_0A_41_14_41_01_1B_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h0A);
    add_test("select_false", 8, 320'h42_0A_42_14_41_00_1B_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I64, 64'h14);
    add_test("drop_all", 7, 320'h41_01_42_02_1A_1A_0B,
             wasm_pkg::TRAP_ENDED, 1'b1, wasm_pkg::VT_I32, 64'h0);
    // Traps leave the stack as it was before the failing instruction
    add_test("add_mixed_types", 6, 320'h41_01_42_02_6A_0B,
             wasm_pkg::TRAP_TYPE_MISMATCH, 1'b0, wasm_pkg::VT_I64, 64'h2);
    add_test("select_i64_cond", 8, 320'h41_01_41_02_42_01_1B_0B,
             wasm_pkg::TRAP_TYPE_MISMATCH, 1'b0, wasm_pkg::VT_I64, 64'h1);
    add_test("add_one_entry", 4, 320'h41_07_6A_0B,
             wasm_pkg::TRAP_STACK_EMPTY, 1'b0, wasm_pkg::VT_I32, 64'h7);
    add_test("push_seventeen", 35,
             {128'h41_01_41_02_41_03_41_04_41_05_41_06_41_07_41_08,
              128'h41_09_41_0A_41_0B_41_0C_41_0D_41_0E_41_0F_41_10,
              24'h41_11_0B},
             wasm_pkg::TRAP_STACK_FULL, 1'b0, wasm_pkg::VT_I32, 64'h10);
    add_test("unreachable", 4, 320'h41_05_00_0B,
             wasm_pkg::TRAP_UNREACHABLE, 1'b0, wasm_pkg::VT_I32, 64'h5);
    add_test("unknown_opcode", 4, 320'h41_05_FF_0B,
             wasm_pkg::TRAP_UNKNOWN_OPCODE, 1'b0, wasm_pkg::VT_I32, 64'h5);
    add_test("nop_passthrough", 6, 320'h01_41_09_01_01_0B,
             wasm_pkg::TRAP_ENDED, 1'b0, wasm_pkg::VT_I32, 64'h9);
  endtask

  task automatic run_test(input int t);
    test_row_t row;
    int        len;
    int        reset_cycles;
    int        errors_before;
    row           = rows[t];
    len           = int'(row.len);
    reset_cycles  = (len > 5) ? len : 5;
    errors_before = error_count;
    // Code is written while the core sits in reset
    @(negedge clk);
    reset = 1'b1;
    for (int i = 0; i < reset_cycles; i++) begin
      load = '0;
      if (i < len) begin
        load.en   = 1'b1;
        load.addr = wasm_pkg::CODE_ADDR_W'(i);
        load.data = row.prog[8*(len-1-i) +: 8];
      end
      @(negedge clk);
    end
    load  = '0;
    reset = 1'b0;
    while (trap == wasm_pkg::TRAP_NONE) begin
      @(negedge clk);
    end
    check_value({names[t], " trap"}, 64'(trap), 64'(row.trap));
    check_value({names[t], " result_empty"}, 64'(result_empty), 64'(row.empty));
    if (!row.empty) begin
      check_value({names[t], " result.vtype"}, 64'(result.vtype), 64'(row.vtype));
      check_value({names[t], " result.value"}, result.value, row.value);
    end
    if (error_count == errors_before) begin
      pass_count++;
      $display("PASS %s", names[t]);
    end else begin
      fail_count++;
      $display("FAIL %s", names[t]);
    end
  endtask

  initial begin
    reset       = 1'b1;
    load        = '0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    cycle_limit = 0;
    run_cycles  = 0;
    build_table();
    for (int t = 0; t < rows.size(); t++) begin
      run_test(t);
    end
    $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
             rows.size(), pass_count, fail_count, i_dut.i_chk.assert_failures);
    if (fail_count == 0 && i_dut.i_chk.assert_failures == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== wasm_core.f ====
rtl/wasm_pkg.sv
rtl/code_mem.sv
rtl/leb128_decoder.sv
rtl/int_alu.sv
rtl/exec_ctrl.sv
rtl/operand_stack.sv
rtl/wasm_core.sv
tests/wasm_core_chk.sv
tests/wasm_core_tb.sv
